/* Makefile */
# Verilator build and run for the bridge testbench

VERILATOR ?= verilator
TOP       ?= apciBridgeTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx 'Test OK'

clean:
	rm -rf $(BUILD_DIR)

/* hdl/apciBridgeTop.sv */
/*
 Bridge top level for ATA access and local bus sharing
 Plain pins only, one instance per function
*/
module apciBridgeTop import apciBusPkg::*; (
    input  logic       clk40,
    input  logic       rstN,
    input  logic       tsN,
    input  logic       rnw,
    input  logic       ataEnN,
    input  logic       ppio,
    input  logic       spio,
    input  logic       pcs0,
    input  logic       pcs1,
    input  logic       scs0,
    input  logic       scs1,
    input  logic [1:0] siz,
    input  logic       brN,
    output logic       tackN,
    output logic       teaN,
    output logic       tciN,
    output logic       tbiN,
    output logic       busDir,
    output logic       ideLenN,
    output logic       ideHrenN,
    output logic       ideHwenN,
    output logic       ideDir,
    output logic       ataLatch,
    output logic       bgN,
    output logic       burstN,
    output logic       cs0PriN,
    output logic       cs1PriN,
    output logic       cs0SecN,
    output logic       cs1SecN,
    output logic       diorPriN,
    output logic       diowPriN,
    output logic       diorSecN,
    output logic       diowSecN
);

    logic ataStart;
    logic ataTack;
    logic ataTea;
    logic cycleActive;

    //////////////////////////////////////////////////
    // ATA path
    //////////////////////////////////////////////////

    ataController ataCtrl_i (.*);

    cycleTermination cycleTerm_i (.*);

    //////////////////////////////////////////////////
    // Buffers and arbitration
    //////////////////////////////////////////////////

    // SIZ pins mapped onto the 040 size type
    bufferControl bufCtrl_i (
        .siz (sizeT'(siz)),
        .*
    );

    busArbiter busArb_i (.*);

endmodule

/* hdl/apciBusPkg.sv */
/*
 Local 68040 bus types for the bridge
 Imported by the buffer control, the arbiter and the top level
*/
package apciBusPkg;

    //////////////////////////////////////////////////
    // Transfer size
    //////////////////////////////////////////////////

    // SIZ pin encoding straight from the 040
    typedef enum logic [1:0] {
        sizLong = 2'b00,
        sizByte = 2'b01,
        sizWord = 2'b10,
        sizLine = 2'b11
    } sizeT;

    //////////////////////////////////////////////////
    // Arbitration
    //////////////////////////////////////////////////

    // Bus parks on the CPU
    typedef enum logic {
        cpuOwns    = 1'b0,
        masterOwns = 1'b1
    } arbStateT;

endpackage

/* hdl/apci_defs.svh */
/*
 Timing and bus settings for the ATA and local bus bridge
 PIO counts are in clk40 cycles
 Include in any block that needs a count width or a buffer direction
*/
`ifndef APCI_DEFS_SVH
`define APCI_DEFS_SVH

// Mode 0 PIO in 25 ns clocks
`define ATA_SLOW_SETUP 3
`define ATA_SLOW_ACTIVE 7
`define ATA_SLOW_RECOVER 14

// Mode 4 PIO
`define ATA_FAST_SETUP 1
`define ATA_FAST_ACTIVE 3
`define ATA_FAST_RECOVER 1

// Phase counter must hold the longest count minus one
`define ATA_CNT_W 4

// CPU data buffer direction per bus owner
`define BUS_DIR_CPU 1'b0
`define BUS_DIR_MASTER 1'b1

`endif

/* hdl/ataChannel.sv */
/*
 PIO strobe sequencer for one ATA channel
 Runs setup, active and recover from the request mode
 Instantiated once per channel by the ATA controller
*/
`include "apci_defs.svh"

module ataChannel import ataPkg::*; (
    input  logic clk40,
    input  logic rstN,
    ataReqIf.chan req,
    output logic csN0,
    output logic csN1,
    output logic diorN,
    output logic diowN
);

    localparam int cntW = `ATA_CNT_W;

    pioPhaseT        phase;
    logic [cntW-1:0] cnt;
    logic [cntW-1:0] setupLen;
    logic [cntW-1:0] activeLen;
    logic [cntW-1:0] recoverLen;
    logic            cs0Q;
    logic            cs1Q;
    logic            rnwQ;
    ataModeT         modeQ;
    ataModeT         modeSel;
    logic            selPhase;

    // Mode from the request in the start cycle, held copy after
    assign modeSel = req.start ? req.mode : modeQ;

    always_comb begin
        if (modeSel == fastPio) begin
            setupLen   = cntW'(`ATA_FAST_SETUP);
            activeLen  = cntW'(`ATA_FAST_ACTIVE);
            recoverLen = cntW'(`ATA_FAST_RECOVER);
        end else begin
            setupLen   = cntW'(`ATA_SLOW_SETUP);
            activeLen  = cntW'(`ATA_SLOW_ACTIVE);
            recoverLen = cntW'(`ATA_SLOW_RECOVER);
        end
    end

    //////////////////////////////////////////////////
    // Phase machine
    //////////////////////////////////////////////////

    // Start cycle counts as the first setup clock
    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            phase <= idle;
            cnt   <= '0;
        end else begin
            case (phase)
                idle: begin
                    if (req.start) begin
                        // One clock of setup is already spent
                        if (setupLen > cntW'(1)) begin
                            phase <= setup;
                            cnt   <= setupLen - cntW'(2);
                        end else begin
                            phase <= active;
                            cnt   <= activeLen - cntW'(1);
                        end
                    end
                end
                setup: begin
                    if (cnt == '0) begin
                        phase <= active;
                        cnt   <= activeLen - cntW'(1);
                    end else begin
                        cnt <= cnt - cntW'(1);
                    end
                end
                active: begin
                    if (cnt == '0) begin
                        phase <= recover;
                        cnt   <= recoverLen - cntW'(1);
                    end else begin
                        cnt <= cnt - cntW'(1);
                    end
                end
                recover: begin
                    if (cnt == '0) begin
                        phase <= idle;
                    end else begin
                        cnt <= cnt - cntW'(1);
                    end
                end
                default: phase <= idle;
            endcase
        end
    end

    // Request fields held for the rest of the sequence
    always_ff @(posedge clk40) begin
        if (req.start) begin
            cs0Q  <= req.cs0;
            cs1Q  <= req.cs1;
            rnwQ  <= req.rnw;
            modeQ <= req.mode;
        end
    end

    //////////////////////////////////////////////////
    // Pins and status
    //////////////////////////////////////////////////

    assign selPhase = (phase == setup) || (phase == active);

    // Select drops in the start cycle itself
    assign csN0 = req.start ? !req.cs0 : !(cs0Q && selPhase);
    assign csN1 = req.start ? !req.cs1 : !(cs1Q && selPhase);

    assign diorN = !((phase == active) && rnwQ);
    assign diowN = !((phase == active) && !rnwQ);

    // Last active clock
    assign req.tack  = (phase == active) && (cnt == '0);
    assign req.latch = req.tack && rnwQ;
    assign req.busy  = (phase != idle);

    // A strobe only moves under an active chip select
    assert property (@(posedge clk40) disable iff (!rstN)
        (!diorN || !diowN) |-> (!csN0 || !csN1));

endmodule

/* hdl/ataController.sv */
/*
 ATA cycle decode and channel dispatch
 Turns a 68040 transfer start into a request for the primary or secondary channel
 Holds one cycle while its channel is still recovering
*/
module ataController import ataPkg::*; (
    input  logic clk40,
    input  logic rstN,
    input  logic tsN,
    input  logic rnw,
    input  logic ataEnN,
    input  logic ppio,
    input  logic spio,
    input  logic pcs0,
    input  logic pcs1,
    input  logic scs0,
    input  logic scs1,
    output logic ataStart,
    output logic ataTack,
    output logic ataTea,
    output logic ataLatch,
    output logic cs0PriN,
    output logic cs1PriN,
    output logic cs0SecN,
    output logic cs1SecN,
    output logic diorPriN,
    output logic diowPriN,
    output logic diorSecN,
    output logic diowSecN
);

    logic    cycleStart, priSel, secSel;
    logic    reqValid, reqSec, reqCs0, reqCs1, reqRnw;
    ataModeT reqMode;
    logic    targetFree, launch;
    logic    pendValid, pendSec, pendCs0, pendCs1, pendRnw;
    ataModeT pendMode;
    logic    cs0Q, cs1Q, rnwQ;
    ataModeT modeQ;

    ataReqIf priIf ();
    ataReqIf secIf ();

    //////////////////////////////////////////////////
    // Cycle decode
    //////////////////////////////////////////////////

    assign cycleStart = !tsN && !ataEnN;
    assign priSel     = pcs0 || pcs1;
    assign secSel     = scs0 || scs1;
    assign ataStart   = cycleStart && (priSel || secSel);
    // No register selected so the cycle ends in error
    assign ataTea     = cycleStart && !priSel && !secSel;

    // Held cycle goes first
    assign reqValid = ataStart || pendValid;
    assign reqSec   = pendValid ? pendSec : secSel;
    assign reqCs0   = pendValid ? pendCs0 : (secSel ? scs0 : pcs0);
    assign reqCs1   = pendValid ? pendCs1 : (secSel ? scs1 : pcs1);
    assign reqRnw   = pendValid ? pendRnw : rnw;
    assign reqMode  = pendValid ? pendMode : ((secSel ? spio : ppio) ? fastPio : slowPio);

    // Channel is free once idle and not just started
    assign targetFree = reqSec ? !(secIf.busy || secIf.start)
                               : !(priIf.busy || priIf.start);
    assign launch     = reqValid && targetFree;

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            priIf.start <= 1'b0;
            secIf.start <= 1'b0;
            pendValid   <= 1'b0;
        end else begin
            priIf.start <= launch && !reqSec;
            secIf.start <= launch && reqSec;
            pendValid   <= reqValid && !targetFree;
        end
    end

    always_ff @(posedge clk40) begin
        if (launch) begin
            cs0Q  <= reqCs0;
            cs1Q  <= reqCs1;
            rnwQ  <= reqRnw;
            modeQ <= reqMode;
        end
        if (reqValid && !targetFree) begin
            pendSec  <= reqSec;
            pendCs0  <= reqCs0;
            pendCs1  <= reqCs1;
            pendRnw  <= reqRnw;
            pendMode <= reqMode;
        end
    end

    // Both channels see the fields, only one gets start
    assign priIf.cs0  = cs0Q;
    assign priIf.cs1  = cs1Q;
    assign priIf.rnw  = rnwQ;
    assign priIf.mode = modeQ;
    assign secIf.cs0  = cs0Q;
    assign secIf.cs1  = cs1Q;
    assign secIf.rnw  = rnwQ;
    assign secIf.mode = modeQ;

    //////////////////////////////////////////////////
    // Channels
    //////////////////////////////////////////////////

    ataChannel priChan (
        .clk40 (clk40),
        .rstN  (rstN),
        .req   (priIf.chan),
        .csN0  (cs0PriN),
        .csN1  (cs1PriN),
        .diorN (diorPriN),
        .diowN (diowPriN)
    );

    ataChannel secChan (
        .clk40 (clk40),
        .rstN  (rstN),
        .req   (secIf.chan),
        .csN0  (cs0SecN),
        .csN1  (cs1SecN),
        .diorN (diorSecN),
        .diowN (diowSecN)
    );

    assign ataTack  = priIf.tack || secIf.tack;
    assign ataLatch = priIf.latch || secIf.latch;

    // Address decode gives one select at most
    assert property (@(posedge clk40) disable iff (!rstN)
        cycleStart |-> $onehot0({pcs0, pcs1, scs0, scs1}));

endmodule

/* hdl/ataPkg.sv */
/*
 ATA PIO types shared by the controller, its channels and their interface
 Imported wherever a phase or a timing mode is handled
*/
package ataPkg;

    //////////////////////////////////////////////////
    // PIO strobe sequence
    //////////////////////////////////////////////////

    // Chip select is low in setup and active
    // Strobe is low in active only
    typedef enum logic [1:0] {
        idle    = 2'b00,
        setup   = 2'b01,
        active  = 2'b10,
        recover = 2'b11
    } pioPhaseT;

    //////////////////////////////////////////////////
    // Timing set
    //////////////////////////////////////////////////

    // Picked per channel from ppio or spio
    typedef enum logic {
        slowPio = 1'b0,
        fastPio = 1'b1
    } ataModeT;

endpackage

/* hdl/ataReqIf.sv */
/*
 Request link from the ATA controller to one PIO channel
 Start is a one cycle pulse, sent only while busy is low
*/
interface ataReqIf import ataPkg::*; ();

    // Request fields, valid in the start cycle
    logic    start;
    logic    rnw;
    logic    cs0;
    logic    cs1;
    ataModeT mode;

    // Channel status
    logic    tack;
    logic    latch;
    logic    busy;

    modport ctrl (
        output start, rnw, cs0, cs1, mode,
        input  tack, latch, busy
    );

    modport chan (
        input  start, rnw, cs0, cs1, mode,
        output tack, latch, busy
    );

endinterface

/* hdl/bufferControl.sv */
/*
 IDE and CPU data buffer steering
 Opens the IDE byte lanes for the active ATA cycle
 Turns the CPU buffer around when the external master owns the bus
*/
`include "apci_defs.svh"

module bufferControl import apciBusPkg::*; (
    input  logic clk40,
    input  logic rstN,
    input  logic cycleActive,
    input  logic rnw,
    input  sizeT siz,
    input  logic bgN,
    output logic ideLenN,
    output logic ideHrenN,
    output logic ideHwenN,
    output logic ideDir,
    output logic busDir,
    output logic burstN
);

    //////////////////////////////////////////////////
    // IDE lanes
    //////////////////////////////////////////////////

    // Lanes open the clock after cycleActive, ahead of the strobe
    // Byte access uses the high lane only
    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            ideLenN  <= 1'b1;
            ideHrenN <= 1'b1;
            ideHwenN <= 1'b1;
            ideDir   <= 1'b0;
        end else begin
            ideLenN  <= !(cycleActive && (siz != sizByte));
            ideHrenN <= !(cycleActive && rnw);
            ideHwenN <= !(cycleActive && !rnw);
            // High for drive to CPU
            ideDir   <= cycleActive && rnw;
        end
    end

    //////////////////////////////////////////////////
    // CPU buffer
    //////////////////////////////////////////////////

    assign busDir = bgN ? `BUS_DIR_CPU : `BUS_DIR_MASTER;
    // Burst allowed for the master only
    assign burstN = bgN;

endmodule

/* hdl/busArbiter.sv */
/*
 Local bus arbiter between the CPU side and an external master
 Parks on the CPU and hands over only while no ATA cycle is open
*/
module busArbiter import apciBusPkg::*; (
    input  logic clk40,
    input  logic rstN,
    input  logic brN,
    input  logic cycleActive,
    output logic bgN
);

    arbStateT state;

    //////////////////////////////////////////////////
    // Owner
    //////////////////////////////////////////////////

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            state <= cpuOwns;
        end else begin
            case (state)
                cpuOwns: begin
                    // Request waits out any open ATA cycle
                    if (!brN && !cycleActive) begin
                        state <= masterOwns;
                    end
                end
                masterOwns: begin
                    if (brN) begin
                        state <= cpuOwns;
                    end
                end
                default: state <= cpuOwns;
            endcase
        end
    end

    assign bgN = (state != masterOwns);

    // Grant never lands inside an open ATA cycle
    assert property (@(posedge clk40) disable iff (!rstN)
        $fell(bgN) |-> !cycleActive);

endmodule

/* hdl/cycleTermination.sv */
/*
 68040 cycle termination for ATA accesses
 Registers tackN and teaN from the controller pulses
 Holds tciN and tbiN low while an ATA cycle is open
*/
module cycleTermination (
    input  logic clk40,
    input  logic rstN,
    input  logic ataStart,
    input  logic ataTack,
    input  logic ataTea,
    output logic tackN,
    output logic teaN,
    output logic tciN,
    output logic tbiN,
    output logic cycleActive
);

    //////////////////////////////////////////////////
    // Termination pins
    //////////////////////////////////////////////////

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            tackN <= 1'b1;
            teaN  <= 1'b1;
        end else begin
            tackN <= !ataTack;
            teaN  <= !ataTea;
        end
    end

    //////////////////////////////////////////////////
    // Active cycle flag
    //////////////////////////////////////////////////

    // Open from the first clock through the tack clock
    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            cycleActive <= 1'b0;
        end else if (ataStart) begin
            cycleActive <= 1'b1;
        end else if (!tackN) begin
            cycleActive <= 1'b0;
        end
    end

    // ATA space is neither cacheable nor burstable
    assign tciN = !cycleActive;
    assign tbiN = !cycleActive;

    // Normal and error termination are exclusive
    assert property (@(posedge clk40) disable iff (!rstN) !(!tackN && !teaN));

endmodule

/* project.f */
+incdir+hdl
hdl/apciBusPkg.sv
hdl/ataPkg.sv
hdl/ataReqIf.sv
hdl/ataChannel.sv
hdl/ataController.sv
hdl/cycleTermination.sv
hdl/bufferControl.sv
hdl/busArbiter.sv
hdl/apciBridgeTop.sv
sim/apciBridgeTb.sv

/* sim/apciBridgeTb.sv */
/*
 Testbench for the ATA and local bus bridge top level
 Drives CPU cycles and bus requests, checks every output with assertions
 Expected pins come from the PIO timing windows relative to the tsN edge
*/
`include "apci_defs.svh"

module apciBridgeTb import apciBusPkg::*; ();

    localparam int resetCycles = 16;
    localparam int pauseBase = 24;
    localparam int pauseSpread = 8;
    localparam int numTests = 6;
    // Longest test is one slow PIO cycle plus its pause
    localparam int testLen = 2 + `ATA_SLOW_SETUP + `ATA_SLOW_ACTIVE + `ATA_SLOW_RECOVER
                             + pauseBase + pauseSpread;
    localparam int watchdogCycles = 4 * (resetCycles + numTests * testLen);

    logic clk40, rstN, tsN, rnw, ataEnN, ppio, spio, pcs0, pcs1, scs0, scs1, brN;
    logic [1:0] siz;
    logic tackN, teaN, tciN, tbiN, busDir, ideLenN, ideHrenN, ideHwenN, ideDir, ataLatch;
    logic bgN, burstN, cs0PriN, cs1PriN, cs0SecN, cs1SecN;
    logic diorPriN, diowPriN, diorSecN, diowSecN;

    // Current cycle and where its edge 0 falls
    int    edgeNo = 0;
    int    edge0 = 0;
    logic  curSel = 1'b0;
    logic  curNoSel = 1'b0;
    logic  curSec, curCs1, curRead, curFast, curByte;
    string testName = "reset";
    int    tackCount = 0;
    int    teaCount = 0;

    logic [7:0] ataPins, expAtaPins;
    logic [4:0] termPins, expTerm;
    logic [3:0] lanePins, expLanes;
    logic [2:0] arbPins, expArb;
    logic       expBgN;

    apciBridgeTop dut_i (.*);

    assign ataPins  = {cs0PriN, cs1PriN, cs0SecN, cs1SecN, diorPriN, diowPriN, diorSecN, diowSecN};
    assign termPins = {tackN, teaN, tciN, tbiN, ataLatch};
    assign lanePins = {ideLenN, ideHrenN, ideHwenN, ideDir};
    assign arbPins  = {bgN, busDir, burstN};

    initial begin
        clk40 = 1'b0;
        forever #4 clk40 = ~clk40;
    end

    always @(posedge clk40) edgeNo <= edgeNo + 1;

    //////////////////////////////////////////////////
    // Expected pins
    //////////////////////////////////////////////////

    always_comb begin
        int rel, s, a, selIdx, strIdx;
        rel = edgeNo - edge0;
        s = curFast ? `ATA_FAST_SETUP : `ATA_SLOW_SETUP;
        a = curFast ? `ATA_FAST_ACTIVE : `ATA_SLOW_ACTIVE;
        // Bit positions in the packed pin vector
        selIdx = 7 - (curSec * 2 + curCs1);
        strIdx = 3 - (curSec * 2 + (curRead ? 0 : 1));
        expAtaPins = '1;
        expTerm = 5'b11110;
        expLanes = 4'b1110;
        if (curNoSel && rel == 1) expTerm[3] = 1'b0;
        if (curSel) begin
            // Select from edge 1, strobe after setup, both rise together
            if (rel >= 1 && rel <= s + a) expAtaPins[selIdx] = 1'b0;
            if (rel >= 1 + s && rel <= s + a) expAtaPins[strIdx] = 1'b0;
            // Cache and burst inhibit through the termination edge
            if (rel >= 1 && rel <= s + a + 1) expTerm[2:1] = 2'b00;
            if (rel == s + a + 1) expTerm[4] = 1'b0;
            if (rel == s + a && curRead) expTerm[0] = 1'b1;
            // Lanes follow the open cycle one clock late
            if (rel >= 2 && rel <= s + a + 2) begin
                expLanes = {curByte, !curRead, curRead, curRead};
            end
        end
    end

    // Bus owner only changes while no ATA cycle is open
    always @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            expBgN <= 1'b1;
        end else if (brN) begin
            expBgN <= 1'b1;
        end else if (expTerm[2]) begin
            expBgN <= 1'b0;
        end
    end

    assign expArb = {expBgN, expBgN ? `BUS_DIR_CPU : `BUS_DIR_MASTER, expBgN};

    always @(posedge clk40) begin
        if (rstN && !tackN) tackCount <= tackCount + 1;
        if (rstN && !teaN) teaCount <= teaCount + 1;
    end

    //////////////////////////////////////////////////
    // Failure reporting and checks
    //////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string what, input logic [7:0] expV,
                                  input logic [7:0] actV);
        abortRun($sformatf("[ERROR] %s %s: expected %b actual %b", testName, what, expV, actV));
    endtask

    assert property (@(posedge clk40) disable iff (!rstN) ataPins == expAtaPins)
        else reportMismatch("chip selects and strobes", $sampled(expAtaPins), $sampled(ataPins));
    assert property (@(posedge clk40) disable iff (!rstN) termPins == expTerm)
        else reportMismatch("termination", 8'($sampled(expTerm)), 8'($sampled(termPins)));
    assert property (@(posedge clk40) disable iff (!rstN) lanePins == expLanes)
        else reportMismatch("IDE buffers", 8'($sampled(expLanes)), 8'($sampled(lanePins)));
    assert property (@(posedge clk40) disable iff (!rstN) arbPins == expArb)
        else reportMismatch("arbitration", 8'($sampled(expArb)), 8'($sampled(arbPins)));

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////

    // One clock of tsN, edge 0 is the next rising edge
    task automatic startCycle(input logic sec, input logic cs1, input logic read,
                              input logic fast, input logic byteAcc, input logic noSel);
        @(posedge clk40);
        tsN <= 1'b0;
        ataEnN <= 1'b0;
        rnw <= read;
        siz <= byteAcc ? sizByte : sizWord;
        pcs0 <= !noSel && !sec && !cs1;
        pcs1 <= !noSel && !sec && cs1;
        scs0 <= !noSel && sec && !cs1;
        scs1 <= !noSel && sec && cs1;
        if (sec) spio <= fast;
        else ppio <= fast;
        curSel <= !noSel;
        curNoSel <= noSel;
        curSec <= sec;
        curCs1 <= cs1;
        curRead <= read;
        curFast <= fast;
        curByte <= byteAcc;
        edge0 <= edgeNo + 1;
        @(posedge clk40);
        tsN <= 1'b1;
        ataEnN <= 1'b1;
        {pcs0, pcs1, scs0, scs1} <= 4'b0000;
    endtask

    task automatic waitForTack(input int limit);
        int n;
        n = 0;
        while (tackN) begin
            if (n == limit) abortRun("tackN never came back for the ATA cycle");
            n++;
            @(posedge clk40);
        end
    endtask

    task automatic waitForGrant(input logic level, input int limit);
        int n;
        n = 0;
        @(posedge clk40);
        while (bgN !== level) begin
            if (n == limit) abortRun("bgN did not reach the requested level in time");
            n++;
            @(posedge clk40);
        end
    endtask

    // Long enough for the slow recovery to finish
    task automatic idlePause();
        int n;
        n = pauseBase + int'($urandom % pauseSpread);
        repeat (n) @(posedge clk40);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hc616_7fcc));
        rstN = 1'b0;
        tsN = 1'b1;
        rnw = 1'b1;
        ataEnN = 1'b1;
        {ppio, spio} = 2'b00;
        {pcs0, pcs1, scs0, scs1} = 4'b0000;
        siz = sizWord;
        brN = 1'b1;
        repeat (resetCycles) @(posedge clk40);
        rstN <= 1'b1;
        idlePause();

        testName = "slow primary byte read";
        startCycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        waitForTack(20);
        idlePause();

        testName = "fast secondary word write";
        startCycle(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        waitForTack(10);
        idlePause();

        testName = "fast primary word read";
        startCycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        waitForTack(10);
        idlePause();

        testName = "no select";
        startCycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        idlePause();

        testName = "idle grant";
        @(posedge clk40);
        brN <= 1'b0;
        waitForGrant(1'b0, 4);
        repeat (3) @(posedge clk40);
        brN <= 1'b1;
        waitForGrant(1'b1, 4);
        idlePause();

        // Request lands in the middle of the strobe sequence
        testName = "grant after cycle";
        startCycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        repeat (3) @(posedge clk40);
        brN <= 1'b0;
        waitForTack(20);
        waitForGrant(1'b0, 6);
        repeat (2) @(posedge clk40);
        brN <= 1'b1;
        waitForGrant(1'b1, 4);
        idlePause();

        if (tackCount == 4 && teaCount == 1) begin
            $display("Test OK");
            $finish;
        end else begin
            reportMismatch("termination count", 8'h41, 8'(tackCount * 16 + teaCount));
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk40);
        abortRun("Watchdog expired before the tests finished");
    end

endmodule
